// File: Bender.yml
package:
  name: rv_soc

sources:
  - logic/rv_pkg.sv
  - logic/mem_port_if.sv
  - logic/rv_regfile.sv
  - logic/rv_alu.sv
  - logic/rv_core.sv
  - logic/ram_io_hub.sv
  - logic/rv_soc.sv
  - target: simulation
    files:
      - dv/rv_soc_chk.sv
      - dv/rv_soc_tb.sv

// File: dv/rv_soc_chk.sv
// ##############################
// bus and pause assertions
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_soc_chk (
  input logic                clk_in,
  input logic                i_rst_n,
  input logic                i_pause,
  input logic                i_halted,
  input rv_pkg::core_state_e i_state,
  input logic [31:0]         i_addr,
  input logic [7:0]          i_wdata,
  input logic                i_wr,
  input logic                i_tx_valid,
  input logic [7:0]          i_tx_data
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  // one unpaused edge after the stop the core sits in HALT and leaves the bus alone
  a_halt_quiet: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    (i_halted && $past(i_halted) && !$past(i_pause)) |->
      (i_state == rv_pkg::HALT && !i_wr))
    else begin
      $error("core not halted or wrote to the bus after the stop");
      fail_cnt++;
    end

  // frozen core, frozen bus
  a_pause_hold: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    (i_pause && $past(i_pause)) |-> ($stable(i_addr) && $stable(i_wdata) && !i_wr))
    else begin
      $error("bus outputs moved while the core was paused");
      fail_cnt++;
    end

  a_tx_nonzero: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    i_tx_valid |-> (i_tx_data != 8'd0))
    else begin
      $error("tx strobe came with a zero byte");
      fail_cnt++;
    end

endmodule

bind rv_soc rv_soc_chk rv_soc_chk_inst (
  .clk_in     (clk_in),
  .i_rst_n    (i_rst_n),
  .i_pause    (pause_q),
  .i_halted   (o_halted),
  .i_state    (rv_core_inst.state_q),
  .i_addr     (bus.addr),
  .i_wdata    (bus.wdata),
  .i_wr       (bus.wr),
  .i_tx_valid (o_tx_valid),
  .i_tx_data  (o_tx_data)
);

`default_nettype wire

// File: dv/rv_soc_tb.sv
// ##############################
// rv32i soc testbench
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_soc_tb;

  // about 5000 cycles of work over five tests plus margin for the stalled rerun
  localparam int MAX_CYCLES = 20000;

  logic        clk_in;
  logic        i_rst_n;
  logic        i_rdy;
  logic        i_io_full;
  logic [7:0]  i_rx_data;
  logic        i_prog_we;
  logic [31:0] i_prog_addr;
  logic [7:0]  i_prog_data;
  logic [7:0]  o_tx_data;
  logic        o_tx_valid;
  logic        o_halted;
  logic [31:0] o_dbg_reg;

  logic [31:0] prog [$];      // program words, address 0 upward
  logic [7:0]  tx_q [$];      // bytes seen on the tx port
  logic [7:0]  io_bytes [6];  // bytes stored by the io program
  logic [7:0]  rx_byte;
  logic [31:0] lfsr = 32'h13ea_aec9;
  int          errors = 0;
  int          checks = 0;
  int          pause_held = 0;
  int          cycle_cnt = 0;

  rv_soc #(
    .RAM_ADDR_W (12)
  ) rv_soc_inst (
    .clk_in      (clk_in),
    .i_rst_n     (i_rst_n),
    .i_rdy       (i_rdy),
    .i_io_full   (i_io_full),
    .i_rx_data   (i_rx_data),
    .i_prog_we   (i_prog_we),
    .i_prog_addr (i_prog_addr),
    .i_prog_data (i_prog_data),
    .o_tx_data   (o_tx_data),
    .o_tx_valid  (o_tx_valid),
    .o_halted    (o_halted),
    .o_dbg_reg   (o_dbg_reg)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_pkg::OP_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  // lui + addi with the upper part rounded for the signed low half
  task automatic put_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    prog.push_back(enc_u(hi[31:12], rd));
    prog.push_back(enc_i(v, rd, 3'b000, rd, rv_pkg::OP_IMM));
  endtask

  task automatic put_stop();
    prog.push_back(enc_u(rv_pkg::IO_BASE[31:12], 5'd5));
    prog.push_back(enc_s(rv_pkg::IO_STOP - rv_pkg::IO_BASE, 5'd0, 5'd5, 3'b000));
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %s done, %0d errors", name, errors - start);
  endtask

  // load with the core paused and reset it before running to the stop write
  task automatic run_program(input bit stall);
    logic [31:0] r;
    @(negedge clk_in);
    i_rdy     = 1'b0;
    i_io_full = 1'b0;
    @(negedge clk_in);
    foreach (prog[i]) begin
      for (int k = 0; k < 4; k++) begin
        i_prog_we   = 1'b1;
        i_prog_addr = 4 * i + k;
        i_prog_data = prog[i][8*k +: 8];
        @(negedge clk_in);
      end
    end
    i_prog_we = 1'b0;
    i_rst_n   = 1'b0;
    repeat (2) @(negedge clk_in);
    tx_q.delete();
    i_rst_n = 1'b1;
    i_rdy   = 1'b1;
    while (!o_halted) begin
      @(negedge clk_in);
      if (stall) begin
        r         = rand_bits(4);
        i_rdy     = r[0] | r[1];  // ready about 3 cycles in 4
        i_io_full = r[2] & r[3];
      end
    end
    i_rdy     = 1'b1;
    i_io_full = 1'b0;
  endtask

  task automatic test_arith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] exp;
    logic [31:0] r;
    string       name;
    int          start;
    start = errors;
    for (int round = 0; round < 2; round++) begin
      a   = rand_bits(32);
      b   = rand_bits(32);
      r   = rand_bits(12);
      imm = {{20{r[11]}}, r[11:0]};
      for (int op = 0; op < 8; op++) begin
        prog.delete();
        put_const(5'd11, a);
        put_const(5'd12, b);
        case (op)
          0: begin
            name = "lui";
            exp  = {a[31:12], 12'd0};
            prog.push_back(enc_u(a[31:12], 5'd10));
          end
          1: begin
            name = "addi";
            exp  = a + imm;
            prog.push_back(enc_i(imm, 5'd11, 3'b000, 5'd10, rv_pkg::OP_IMM));
          end
          2: begin
            name = "add";
            exp  = a + b;
            prog.push_back(enc_r(7'd0, 5'd12, 5'd11, 3'b000, 5'd10));
          end
          3: begin
            name = "sub";
            exp  = a - b;
            prog.push_back(enc_r(7'b0100000, 5'd12, 5'd11, 3'b000, 5'd10));
          end
          4: begin
            name = "and";
            exp  = a & b;
            prog.push_back(enc_r(7'd0, 5'd12, 5'd11, 3'b111, 5'd10));
          end
          5: begin
            name = "or";
            exp  = a | b;
            prog.push_back(enc_r(7'd0, 5'd12, 5'd11, 3'b110, 5'd10));
          end
          6: begin
            name = "xor";
            exp  = a ^ b;
            prog.push_back(enc_r(7'd0, 5'd12, 5'd11, 3'b100, 5'd10));
          end
          default: begin
            name = "slt";
            exp  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            prog.push_back(enc_r(7'd0, 5'd12, 5'd11, 3'b010, 5'd10));
          end
        endcase
        put_stop();
        run_program(1'b0);
        check_value({"arith ", name}, exp, o_dbg_reg);
      end
    end
    report_test("arith", start);
  endtask

  task automatic test_load_store();
    logic [31:0] w;
    logic [31:0] exp;
    logic [31:0] r;
    logic [7:0]  sb_val;
    logic [7:0]  b;
    int          start;
    start  = errors;
    w      = (rand_bits(32) & 32'h7f7f_7f7f) | 32'h8000_8000;  // bytes 1 and 3 negative
    r      = rand_bits(8);
    sb_val = r[7:0];
    for (int kind = 0; kind < 4; kind++) begin
      for (int k = 0; k < 4; k++) begin
        prog.delete();
        put_const(5'd11, 32'h800);
        put_const(5'd12, w);
        prog.push_back(enc_s(0, 5'd12, 5'd11, 3'b010));  // sw
        b = w[8*k +: 8];
        case (kind)
          0: begin
            exp = {{24{b[7]}}, b};
            prog.push_back(enc_i(k, 5'd11, 3'b000, 5'd10, rv_pkg::OP_LOAD));
          end
          1: begin
            exp = {24'd0, b};
            prog.push_back(enc_i(k, 5'd11, 3'b100, 5'd10, rv_pkg::OP_LOAD));
          end
          2: begin
            exp = w;
            prog.push_back(enc_i(0, 5'd11, 3'b010, 5'd10, rv_pkg::OP_LOAD));
          end
          default: begin
            exp           = w;
            exp[8*k +: 8] = sb_val;  // sb over one byte of the word
            put_const(5'd13, {24'd0, sb_val});
            prog.push_back(enc_s(k, 5'd13, 5'd11, 3'b000));
            prog.push_back(enc_i(0, 5'd11, 3'b010, 5'd10, rv_pkg::OP_LOAD));
          end
        endcase
        put_stop();
        run_program(1'b0);
        check_value($sformatf("load kind %0d offset %0d", kind, k), exp, o_dbg_reg);
        if (kind == 2)
          break;  // lw only at offset 0
      end
    end
    report_test("load_store", start);
  endtask

  task automatic test_branch();
    logic [31:0] n;
    int          start;
    start = errors;
    n     = 5 + rand_bits(4);
    // blt loop calling a jal/jalr subroutine
    prog.delete();
    prog.push_back(enc_i(n, 5'd0, 3'b000, 5'd11, rv_pkg::OP_IMM));
    prog.push_back(enc_i(0, 5'd0, 3'b000, 5'd10, rv_pkg::OP_IMM));
    prog.push_back(enc_i(0, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IMM));
    prog.push_back(enc_i(1, 5'd12, 3'b000, 5'd12, rv_pkg::OP_IMM));  // loop head at 12
    prog.push_back(enc_j(12, 5'd1));
    prog.push_back(enc_b(-8, 5'd11, 5'd12, 3'b100));
    prog.push_back(enc_j(12, 5'd0));
    prog.push_back(enc_r(7'd0, 5'd12, 5'd10, 3'b000, 5'd10));        // subroutine at 28
    prog.push_back(enc_i(0, 5'd1, 3'b000, 5'd0, rv_pkg::OP_JALR));
    put_stop();
    run_program(1'b0);
    check_value("branch blt sum", n * (n + 1) / 2, o_dbg_reg);
    // bne countdown
    prog.delete();
    prog.push_back(enc_i(n, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IMM));
    prog.push_back(enc_r(7'd0, 5'd12, 5'd10, 3'b000, 5'd10));
    prog.push_back(enc_i(-1, 5'd12, 3'b000, 5'd12, rv_pkg::OP_IMM));
    prog.push_back(enc_b(-8, 5'd0, 5'd12, 3'b001));
    put_stop();
    run_program(1'b0);
    check_value("branch bne sum", n * (n + 1) / 2, o_dbg_reg);
    // link value of a call that returns to address 4
    prog.delete();
    prog.push_back(enc_j(12, 5'd1));
    prog.push_back(enc_i(0, 5'd1, 3'b000, 5'd10, rv_pkg::OP_IMM));
    prog.push_back(enc_j(8, 5'd0));
    prog.push_back(enc_i(0, 5'd1, 3'b000, 5'd0, rv_pkg::OP_JALR));
    put_stop();
    run_program(1'b0);
    check_value("branch jal link", 32'd4, o_dbg_reg);
    report_test("branch", start);
  endtask

  task automatic test_io(input bit stall, input string name);
    logic [7:0]  exp_q [$];
    logic [31:0] r;
    int          start;
    start = errors;
    if (!stall) begin
      for (int i = 0; i < 6; i++) begin
        r           = rand_bits(8);
        io_bytes[i] = (i == 1 || i == 4) ? 8'd0 : (r[7:0] | 8'h01);
      end
      r       = rand_bits(8);
      rx_byte = r[7:0];
    end
    i_rx_data = rx_byte;
    prog.delete();
    prog.push_back(enc_u(rv_pkg::IO_BASE[31:12], 5'd5));
    foreach (io_bytes[i]) begin
      prog.push_back(enc_i({24'd0, io_bytes[i]}, 5'd0, 3'b000, 5'd13, rv_pkg::OP_IMM));
      prog.push_back(enc_s(0, 5'd13, 5'd5, 3'b000));
    end
    prog.push_back(enc_i(0, 5'd5, 3'b100, 5'd10, rv_pkg::OP_LOAD));   // lbu rx byte
    prog.push_back(enc_i(4, 5'd5, 3'b010, 5'd15, rv_pkg::OP_LOAD));   // counter twice
    prog.push_back(enc_i(4, 5'd5, 3'b010, 5'd16, rv_pkg::OP_LOAD));
    prog.push_back(enc_b(8, 5'd15, 5'd16, 3'b100));
    prog.push_back(enc_j(8, 5'd0));
    prog.push_back(enc_i(-1, 5'd0, 3'b000, 5'd10, rv_pkg::OP_IMM));  // counter went back
    put_stop();
    run_program(stall);
    repeat (4) @(negedge clk_in);  // halt is a level and no more bytes follow it
    foreach (io_bytes[i]) begin
      if (io_bytes[i] != 8'd0)
        exp_q.push_back(io_bytes[i]);
    end
    check_value({name, " tx count"}, exp_q.size(), tx_q.size());
    foreach (exp_q[i]) begin
      if (i < tx_q.size())
        check_value($sformatf("%s tx byte %0d", name, i), exp_q[i], tx_q[i]);
    end
    check_value({name, " rx and counter"}, {24'd0, rx_byte}, o_dbg_reg);
    check_value({name, " halted"}, 32'd1, {31'd0, o_halted});
    report_test(name, start);
  endtask

  // the tx strobe may trail a pause by one cycle at most
  always @(posedge clk_in) begin
    if (!i_rdy || i_io_full)
      pause_held <= pause_held + 1;
    else
      pause_held <= 0;
  end

  always @(negedge clk_in) begin
    if (o_tx_valid) begin
      tx_q.push_back(o_tx_data);
      if (pause_held >= 2) begin
        $display("tx strobe seen %0d cycles into a pause", pause_held);
        errors++;
      end
    end
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_in);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    i_rst_n     = 1'b0;
    i_rdy       = 1'b0;
    i_io_full   = 1'b0;
    i_rx_data   = 8'd0;
    i_prog_we   = 1'b0;
    i_prog_addr = 32'd0;
    i_prog_data = 8'd0;
    repeat (2) @(negedge clk_in);
    i_rst_n = 1'b1;

    test_arith();
    test_load_store();
    test_branch();
    test_io(1'b0, "io");
    test_io(1'b1, "io_pause");

    errors = errors + rv_soc_inst.rv_soc_chk_inst.fail_cnt;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/rv_pkg.sv
logic/mem_port_if.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_core.sv
logic/ram_io_hub.sv
logic/rv_soc.sv
dv/rv_soc_chk.sv
dv/rv_soc_tb.sv

// File: logic/mem_port_if.sv
// ##############################
// byte memory bus
// ##############################
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
  logic [31:0] addr;
  logic [7:0]  wdata;
  logic [7:0]  rdata;  // answer to the address of the previous cycle
  logic        wr;     // 1 for write

  modport core (
    output addr,
    output wdata,
    output wr,
    input  rdata
  );

  modport mem (
    input  addr,
    input  wdata,
    input  wr,
    output rdata
  );
endinterface

`default_nettype wire

// File: logic/ram_io_hub.sv
// ##############################
// ram and i/o hub
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ram_io_hub #(
  parameter int RAM_ADDR_W = 17
) (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_pause,
  mem_port_if.mem     mem,
  input  logic [7:0]  i_rx_data,
  input  logic        i_prog_we,
  input  logic [31:0] i_prog_addr,
  input  logic [7:0]  i_prog_data,
  output logic [7:0]  o_tx_data,
  output logic        o_tx_valid,
  output logic        o_halted
);

  logic [7:0]  ram [0:(2**RAM_ADDR_W)-1];
  logic [7:0]  rdata_q;
  logic [31:0] cycle_q;
  logic [31:0] snap_q;  // counter copy so a 4-byte read is coherent
  logic        io_sel;
  logic        tx_hit;

  assign io_sel = (mem.addr[17:16] == 2'b11);
  assign tx_hit = mem.wr && (mem.addr == rv_pkg::IO_BASE) && (mem.wdata != 8'd0);

  always_ff @(posedge clk_in) begin
    if (i_prog_we)
      ram[i_prog_addr[RAM_ADDR_W-1:0]] <= i_prog_data;  // loader wins
    else if (mem.wr && !io_sel)
      ram[mem.addr[RAM_ADDR_W-1:0]] <= mem.wdata;

    // read data holds while paused so the core sees the answer it asked for
    if (!i_pause) begin
      if (!io_sel) begin
        rdata_q <= ram[mem.addr[RAM_ADDR_W-1:0]];
      end else if (mem.addr[2]) begin
        if (mem.addr[1:0] == 2'd0) begin
          rdata_q <= cycle_q[7:0];
          snap_q  <= cycle_q;
        end else begin
          rdata_q <= snap_q[8*mem.addr[1:0] +: 8];
        end
      end else begin
        rdata_q <= i_rx_data;
      end
    end
  end

  assign mem.rdata = rdata_q;

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cycle_q    <= '0;
      o_tx_data  <= '0;
      o_tx_valid <= 1'b0;
      o_halted   <= 1'b0;
    end else begin
      cycle_q    <= cycle_q + 32'd1;  // free running
      o_tx_valid <= tx_hit;
      if (tx_hit)
        o_tx_data <= mem.wdata;
      if (mem.wr && mem.addr == rv_pkg::IO_STOP)
        o_halted <= 1'b1;  // sticky until reset
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
// ##############################
// alu and branch compare
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_e i_op,
  input  logic [31:0]     i_a,
  input  logic [31:0]     i_b,
  output logic [31:0]     o_result,
  output logic            o_cond
);

  logic lt;

  assign lt = $signed(i_a) < $signed(i_b);

  always_comb begin
    o_result = i_a + i_b;  // add also serves address and jalr target
    o_cond   = 1'b0;
    case (i_op)
      rv_pkg::SUB: begin
        o_result = i_a - i_b;
      end
      rv_pkg::AND: begin
        o_result = i_a & i_b;
      end
      rv_pkg::OR: begin
        o_result = i_a | i_b;
      end
      rv_pkg::XOR: begin
        o_result = i_a ^ i_b;
      end
      rv_pkg::SLT: begin
        o_result = {31'd0, lt};
      end
      // branch conditions
      rv_pkg::EQ: begin
        o_cond = (i_a == i_b);
      end
      rv_pkg::NE: begin
        o_cond = (i_a != i_b);
      end
      rv_pkg::LT: begin
        o_cond = lt;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
// ##############################
// multi-cycle rv32i core
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_pause,
  mem_port_if.core    mem,
  input  logic        i_halted,
  output logic [31:0] o_dbg_reg
);

  rv_pkg::core_state_e state_q;
  rv_pkg::alu_op_e     alu_op_q;
  rv_pkg::alu_op_e     alu_op;
  rv_pkg::opcode_e     opcode;

  logic [31:0] pc_q;
  logic [31:0] ir_q;   // instruction word
  logic [31:0] imm_q;
  logic [31:0] alu_q;  // result, or effective address for loads and stores
  logic [31:0] npc_q;
  logic [31:0] ld_q;   // load bytes enter at the top
  logic [2:0]  cnt_q;  // byte step inside FETCH and MEM

  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_res;
  logic        alu_cond;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  logic [31:0] wb_data;
  logic        is_ld;
  logic        is_st;
  logic        wide;
  logic        rd_we;
  logic        mem_last;

  assign opcode = rv_pkg::opcode_e'(ir_q[6:0]);
  assign rd     = ir_q[11:7];
  assign funct3 = ir_q[14:12];
  assign rs1    = ir_q[19:15];
  assign rs2    = ir_q[24:20];

  // immediate by format
  always_comb begin
    case (opcode)
      rv_pkg::OP_LUI:    imm = {ir_q[31:12], 12'd0};
      rv_pkg::OP_JAL:    imm = {{12{ir_q[31]}}, ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
      rv_pkg::OP_BRANCH: imm = {{20{ir_q[31]}}, ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
      rv_pkg::OP_STORE:  imm = {{21{ir_q[31]}}, ir_q[30:25], ir_q[11:7]};
      default:           imm = {{21{ir_q[31]}}, ir_q[30:20]};
    endcase
  end

  always_comb begin
    alu_op = rv_pkg::ADD;
    case (opcode)
      rv_pkg::OP_REG, rv_pkg::OP_IMM: begin
        case (funct3)
          3'b000:  alu_op = (opcode == rv_pkg::OP_REG && ir_q[30]) ? rv_pkg::SUB : rv_pkg::ADD;
          3'b010:  alu_op = rv_pkg::SLT;
          3'b100:  alu_op = rv_pkg::XOR;
          3'b110:  alu_op = rv_pkg::OR;
          3'b111:  alu_op = rv_pkg::AND;
          default: alu_op = rv_pkg::ADD;
        endcase
      end
      rv_pkg::OP_BRANCH: begin
        case (funct3)
          3'b000:  alu_op = rv_pkg::EQ;
          3'b001:  alu_op = rv_pkg::NE;
          3'b100:  alu_op = rv_pkg::LT;
          default: alu_op = rv_pkg::ADD;  // never taken
        endcase
      end
      default: alu_op = rv_pkg::ADD;
    endcase
  end

  // supported widths only, others fall through as nops
  assign is_ld = (opcode == rv_pkg::OP_LOAD) &&
                 (funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b010);
  assign is_st = (opcode == rv_pkg::OP_STORE) && (funct3 == 3'b000 || funct3 == 3'b010);
  assign wide  = (funct3 == 3'b010);

  // loads need one extra step for the last byte
  assign mem_last = (cnt_q == (is_ld ? (wide ? 3'd4 : 3'd1) : (wide ? 3'd3 : 3'd0)));

  always_comb begin
    case (opcode)
      rv_pkg::OP_LUI, rv_pkg::OP_JAL, rv_pkg::OP_JALR: rd_we = 1'b1;
      rv_pkg::OP_LOAD:                                 rd_we = is_ld;
      rv_pkg::OP_REG, rv_pkg::OP_IMM:
        rd_we = (funct3 != 3'b001) && (funct3 != 3'b011) && (funct3 != 3'b101);
      default:                                         rd_we = 1'b0;
    endcase
  end

  assign alu_a     = (opcode == rv_pkg::OP_LUI) ? 32'd0 : rs1_val;
  assign alu_b     = (opcode == rv_pkg::OP_REG || opcode == rv_pkg::OP_BRANCH) ? rs2_val : imm_q;
  assign pc_plus4  = pc_q + 32'd4;
  assign pc_target = pc_q + imm_q;

  always_comb begin
    case (opcode)
      rv_pkg::OP_LOAD: begin
        if (wide)
          wb_data = ld_q;
        else if (funct3[2])
          wb_data = {24'd0, ld_q[31:24]};  // lbu
        else
          wb_data = {{24{ld_q[31]}}, ld_q[31:24]};
      end
      rv_pkg::OP_JAL, rv_pkg::OP_JALR: wb_data = pc_plus4;
      default:                         wb_data = alu_q;
    endcase
  end

  // byte bus, outputs only change on unpaused edges
  assign mem.addr  = (state_q == rv_pkg::FETCH) ? pc_q + {29'd0, cnt_q} : alu_q + {29'd0, cnt_q};
  assign mem.wdata = rs2_val[8*cnt_q[1:0] +: 8];
  assign mem.wr    = (state_q == rv_pkg::MEM) && is_st && !i_pause;

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= rv_pkg::FETCH;
      pc_q     <= '0;
      cnt_q    <= '0;
      ir_q     <= '0;
      imm_q    <= '0;
      alu_op_q <= rv_pkg::ADD;
      alu_q    <= '0;
      npc_q    <= '0;
    end else if (!i_pause) begin
      if (i_halted) begin
        state_q <= rv_pkg::HALT;
      end else begin
        case (state_q)
          rv_pkg::FETCH: begin
            if (cnt_q != 3'd0)
              ir_q <= {mem.rdata, ir_q[31:8]};  // little-endian gather
            if (cnt_q == 3'd4) begin
              cnt_q   <= '0;
              state_q <= rv_pkg::DECODE;
            end else begin
              cnt_q <= cnt_q + 3'd1;
            end
          end
          rv_pkg::DECODE: begin
            imm_q    <= imm;
            alu_op_q <= alu_op;
            state_q  <= rv_pkg::EXEC;
          end
          rv_pkg::EXEC: begin
            alu_q <= alu_res;
            case (opcode)
              rv_pkg::OP_BRANCH: npc_q <= alu_cond ? pc_target : pc_plus4;
              rv_pkg::OP_JAL:    npc_q <= pc_target;
              rv_pkg::OP_JALR:   npc_q <= {alu_res[31:1], 1'b0};
              default:           npc_q <= pc_plus4;
            endcase
            state_q <= (is_ld || is_st) ? rv_pkg::MEM : rv_pkg::WB;
          end
          rv_pkg::MEM: begin
            if (mem_last) begin
              cnt_q   <= '0;
              state_q <= rv_pkg::WB;
            end else begin
              cnt_q <= cnt_q + 3'd1;
            end
          end
          rv_pkg::WB: begin
            pc_q    <= npc_q;
            state_q <= rv_pkg::FETCH;
          end
          default: begin  // HALT, stay
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!i_pause && state_q == rv_pkg::MEM && cnt_q != 3'd0)
      ld_q <= {mem.rdata, ld_q[31:8]};
  end

  rv_regfile rv_regfile_inst (
    .clk_in   (clk_in),
    .i_rst_n  (i_rst_n),
    .i_pause  (i_pause),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_we     ((state_q == rv_pkg::WB) && rd_we),
    .i_rd     (rd),
    .i_wdata  (wb_data),
    .o_rdata1 (rs1_val),
    .o_rdata2 (rs2_val),
    .o_x10    (o_dbg_reg)
  );

  rv_alu rv_alu_inst (
    .i_op     (alu_op_q),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_res),
    .o_cond   (alu_cond)
  );

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
// ##############################
// rv32i shared definitions
// ##############################
`default_nettype none

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT,
    EQ, NE, LT                       // compares, drive the condition only
  } alu_op_e;

  typedef enum logic [2:0] {
    FETCH, DECODE, EXEC, MEM, WB, HALT
  } core_state_e;

  // i/o map, anything with addr[17:16] == 3 is i/o
  localparam logic [31:0] IO_BASE = 32'h0003_0000;  // byte in / byte out
  localparam logic [31:0] IO_STOP = 32'h0003_0004;  // cycle counter / stop

endpackage

`default_nettype wire

// File: logic/rv_regfile.sv
// ##############################
// rv32i register file
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_pause,
  input  logic [4:0]  i_rs1,
  input  logic [4:0]  i_rs2,
  input  logic        i_we,
  input  logic [4:0]  i_rd,
  input  logic [31:0] i_wdata,
  output logic [31:0] o_rdata1,
  output logic [31:0] o_rdata2,
  output logic [31:0] o_x10
);

  logic [31:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && !i_pause && i_rd != 5'd0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // asynchronous reads
  assign o_rdata1 = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
  assign o_rdata2 = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

  assign o_x10 = regs[10];  // a0, debug view

endmodule

`default_nettype wire

// File: logic/rv_soc.sv
// ##############################
// rv32i soc top
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rv_soc #(
  parameter int RAM_ADDR_W = 17
) (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_rdy,
  input  logic        i_io_full,
  input  logic [7:0]  i_rx_data,
  input  logic        i_prog_we,
  input  logic [31:0] i_prog_addr,
  input  logic [7:0]  i_prog_data,
  output logic [7:0]  o_tx_data,
  output logic        o_tx_valid,
  output logic        o_halted,
  output logic [31:0] o_dbg_reg
);

  logic pause_q;

  mem_port_if bus ();

  // pause follows the inputs one cycle late
  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n)
      pause_q <= 1'b1;
    else
      pause_q <= !i_rdy || i_io_full;
  end

  rv_core rv_core_inst (
    .clk_in    (clk_in),
    .i_rst_n   (i_rst_n),
    .i_pause   (pause_q),
    .mem       (bus.core),
    .i_halted  (o_halted),
    .o_dbg_reg (o_dbg_reg)
  );

  ram_io_hub #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) ram_io_hub_inst (
    .clk_in      (clk_in),
    .i_rst_n     (i_rst_n),
    .i_pause     (pause_q),
    .mem         (bus.mem),
    .i_rx_data   (i_rx_data),
    .i_prog_we   (i_prog_we),
    .i_prog_addr (i_prog_addr),
    .i_prog_data (i_prog_data),
    .o_tx_data   (o_tx_data),
    .o_tx_valid  (o_tx_valid),
    .o_halted    (o_halted)
  );

endmodule

`default_nettype wire
